/* verilog/fir_cfg_pkg.sv */
// FIR accelerator register map: offsets, tap count, access targets and the control word layout
package fir_cfg_pkg;

  // Register word width
  localparam int REG_W = 32;

  // Tap memory geometry
  localparam int TAP_NUM = 11;
  localparam int TAP_AW  = 4;

  // Byte offsets in the config space
  localparam int unsigned CTRL_OFFSET = 'h00;
  localparam int unsigned LEN_OFFSET  = 'h10;
  localparam int unsigned TAP_BASE    = 'h40;
  // Last tap word, taps are word spaced
  localparam int unsigned TAP_LAST    = TAP_BASE + 4 * (TAP_NUM - 1);

  // Which storage an access lands in
  typedef enum logic [1:0] {
    TGT_CTRL = 2'd0,
    TGT_LEN  = 2'd1,
    TGT_TAP  = 2'd2,
    TGT_NONE = 2'd3
  } cfg_target_t;

  // Control register bit layout
  typedef struct packed {
    logic [REG_W-4:0] reserved;
    logic             ap_idle;
    logic             ap_done;
    logic             ap_start;
  } ctrl_word_t;

  // One register word, seen raw or as control bits
  typedef union packed {
    logic [REG_W-1:0] raw;
    ctrl_word_t       ctrl;
  } cfg_word_u;

endpackage

/* verilog/axil_pkg.sv */
// Bus-side definitions for the AXI4-Lite config slave: widths, response codes, access record
package axil_pkg;

  // Bus widths
  localparam int ADDR_W = 12;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // RRESP / BRESP encodings, only the two this slave returns
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_t;

  // One decoded access, handed from capture to the storage blocks
  typedef struct packed {
    logic                      write;
    fir_cfg_pkg::cfg_target_t  target;
    logic [3:0]                index;
    logic [DATA_W-1:0]         wdata;
    logic [STRB_W-1:0]         wstrb;
  } axil_access_t;

  // Byte lane merge of a write word into the old contents
  function automatic logic [DATA_W-1:0] strb_merge(
    input logic [DATA_W-1:0] old_word,
    input logic [DATA_W-1:0] new_word,
    input logic [STRB_W-1:0] strb
  );
    logic [DATA_W-1:0] merged;
    merged = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      // Only lanes with a set strobe take the new byte
      if (strb[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

/* verilog/axil_req_capture.sv */
// Input side of the config slave: takes AR, AW and W, decodes the address, issues one access
`timescale 1ns/1ns

module axil_req_capture
  import axil_pkg::*;
  import fir_cfg_pkg::*;
(
  input  logic              aclk,
  input  logic              aresetn,
  // Read address channel
  input  logic [ADDR_W-1:0] araddr,
  input  logic              arvalid,
  output logic              arready,
  // Write address and data channels
  input  logic [ADDR_W-1:0] awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [DATA_W-1:0] wdata,
  input  logic [STRB_W-1:0] wstrb,
  input  logic              wvalid,
  output logic              wready,
  // Flow control and engine state
  input  logic              resp_busy,
  input  logic              ap_idle,
  // Access towards the storage blocks
  output logic              access_valid,
  output axil_access_t      access,
  output logic              access_err
);

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  function automatic cfg_target_t decode_target(input logic [ADDR_W-1:0] addr);
    cfg_target_t tgt;
    tgt = TGT_NONE;
    // Unaligned addresses never hit
    if (addr[1:0] == 2'b00) begin
      if (addr == ADDR_W'(CTRL_OFFSET)) begin
        tgt = TGT_CTRL;
      end else if (addr == ADDR_W'(LEN_OFFSET)) begin
        tgt = TGT_LEN;
      end else if (addr >= ADDR_W'(TAP_BASE) && addr <= ADDR_W'(TAP_LAST)) begin
        tgt = TGT_TAP;
      end
    end
    return tgt;
  endfunction

  // Word index from the tap base, only meaningful for tap hits
  function automatic logic [TAP_AW-1:0] decode_index(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] offs;
    offs = addr - ADDR_W'(TAP_BASE);
    return offs[TAP_AW+1:2];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////////////////////

  logic         idle_q;
  logic         rd_accept;
  logic         wr_accept;
  axil_access_t next_access;
  logic         next_err;

  // Read wins, a write needs AW and W together
  assign arready   = idle_q;
  assign awready   = idle_q && !arvalid && awvalid && wvalid;
  assign wready    = awready;
  assign rd_accept = arvalid && arready;
  assign wr_accept = awvalid && awready;

  // Idle drops on acceptance and returns once the response is gone
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      idle_q <= 1'b0;
    end else begin
      idle_q <= !(rd_accept || wr_accept) && !resp_busy;
    end
  end

  // Build the access from whichever channel is taken
  always_comb begin
    next_access = '0;
    if (rd_accept) begin
      next_access.target = decode_target(araddr);
      next_access.index  = decode_index(araddr);
    end else begin
      next_access.write  = 1'b1;
      next_access.target = decode_target(awaddr);
      next_access.index  = decode_index(awaddr);
      next_access.wdata  = wdata;
      next_access.wstrb  = wstrb;
    end
    // Unmapped, or tap write while the engine runs
    next_err = (next_access.target == TGT_NONE) ||
               (next_access.write && next_access.target == TGT_TAP && !ap_idle);
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      access_valid <= 1'b0;
    end else begin
      access_valid <= rd_accept || wr_accept;
    end
  end

  // Payload only moves on acceptance
  always_ff @(posedge aclk) begin
    if (rd_accept || wr_accept) begin
      access     <= next_access;
      access_err <= next_err;
    end
  end

endmodule

/* verilog/cfg_reg_block.sv */
// Control/status and data length registers of the FIR accelerator, with start pulse and sticky done
`timescale 1ns/1ns

module cfg_reg_block
  import axil_pkg::*;
  import fir_cfg_pkg::*;
(
  input  logic              aclk,
  input  logic              aresetn,
  // Access from capture
  input  logic              access_valid,
  input  axil_access_t      access,
  input  logic              access_err,
  // Engine handshake
  input  logic              ap_done,
  output logic              ap_start,
  output logic              ap_idle,
  output logic [DATA_W-1:0] data_length,
  // Read data, one cycle after the access
  output logic [DATA_W-1:0] reg_rdata
);

  cfg_word_u wr_word;
  cfg_word_u ctrl_rd;
  logic      done_q;
  logic      hit;
  logic      ctrl_wr;
  logic      ctrl_rd_hit;
  logic      len_wr;
  logic      reg_rd;
  logic      start_req;

  // Only clean accesses to own registers count
  assign hit         = access_valid && !access_err;
  assign ctrl_wr     = hit && access.write && access.target == TGT_CTRL;
  assign ctrl_rd_hit = hit && !access.write && access.target == TGT_CTRL;
  assign len_wr      = hit && access.write && access.target == TGT_LEN;
  assign reg_rd      = hit && !access.write &&
                       (access.target == TGT_CTRL || access.target == TGT_LEN);

  // Decode the incoming word as control bits
  assign wr_word.raw = access.wdata;
  // Start bit lives in byte 0, ignored unless idle
  assign start_req   = ctrl_wr && access.wstrb[0] && wr_word.ctrl.ap_start && ap_idle;

  // Status view, start always reads back 0
  always_comb begin
    ctrl_rd.raw          = '0;
    ctrl_rd.ctrl.ap_done = done_q;
    ctrl_rd.ctrl.ap_idle = ap_idle;
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      ap_start    <= 1'b0;
      ap_idle     <= 1'b1;
      done_q      <= 1'b0;
      data_length <= '0;
    end else begin
      // Single cycle pulse
      ap_start <= 1'b0;
      if (start_req) begin
        ap_start <= 1'b1;
        ap_idle  <= 1'b0;
      end
      // Done is cleared by reading it
      if (ctrl_rd_hit) begin
        done_q <= 1'b0;
      end
      // A done pulse in the same cycle still sticks
      if (ap_done) begin
        done_q  <= 1'b1;
        ap_idle <= 1'b1;
      end
      if (len_wr) begin
        data_length <= strb_merge(data_length, access.wdata, access.wstrb);
      end
    end
  end

  // Registered read mux
  always_ff @(posedge aclk) begin
    if (reg_rd) begin
      reg_rdata <= (access.target == TGT_CTRL) ? ctrl_rd.raw : data_length;
    end
  end

endmodule

/* verilog/tap_ram.sv */
// Tap coefficient memory: byte-writable bus port plus a read-only port for the FIR engine
`timescale 1ns/1ns

module tap_ram
  import axil_pkg::*;
  import fir_cfg_pkg::*;
(
  input  logic              aclk,
  input  logic              aresetn,
  // Bus port
  input  logic              access_valid,
  input  axil_access_t      access,
  input  logic              access_err,
  output logic [DATA_W-1:0] tap_rdata,
  // Engine port
  input  logic [TAP_AW-1:0] tap_raddr,
  output logic [DATA_W-1:0] eng_tap_rdata
);

  logic [DATA_W-1:0] mem [TAP_NUM];
  logic              tap_hit;

  // Rejected accesses never reach the array
  assign tap_hit = access_valid && !access_err && access.target == TGT_TAP;

  // Taps start cleared, each write merges by strobe
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      for (int i = 0; i < TAP_NUM; i++) begin
        mem[i] <= '0;
      end
    end else if (tap_hit && access.write) begin
      mem[access.index] <= strb_merge(mem[access.index], access.wdata, access.wstrb);
    end
  end

  // Bus read, registered
  always_ff @(posedge aclk) begin
    if (tap_hit && !access.write) begin
      tap_rdata <= mem[access.index];
    end
  end

  // Engine read every cycle, zero past the last tap
  always_ff @(posedge aclk) begin
    eng_tap_rdata <= (tap_raddr < TAP_NUM) ? mem[tap_raddr] : '0;
  end

endmodule

/* verilog/axil_resp_gen.sv */
// Output side of the config slave: picks read data, forms RRESP/BRESP, holds R and B until taken
`timescale 1ns/1ns

module axil_resp_gen
  import axil_pkg::*;
  import fir_cfg_pkg::*;
(
  input  logic              aclk,
  input  logic              aresetn,
  // Access from capture
  input  logic              access_valid,
  input  axil_access_t      access,
  input  logic              access_err,
  // Read data from the storage blocks
  input  logic [DATA_W-1:0] reg_rdata,
  input  logic [DATA_W-1:0] tap_rdata,
  // Read data channel
  output logic [DATA_W-1:0] rdata,
  output resp_t             rresp,
  output logic              rvalid,
  input  logic              rready,
  // Write response channel
  output resp_t             bresp,
  output logic              bvalid,
  input  logic              bready,
  // Holds off new addresses
  output logic              resp_busy
);

  logic              pend_q;
  logic              pend_write;
  logic              pend_err;
  cfg_target_t       pend_target;
  logic [DATA_W-1:0] rd_sel;

  // Remember the access while the storage read settles
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      pend_q <= 1'b0;
    end else begin
      pend_q <= access_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (access_valid) begin
      pend_write  <= access.write;
      pend_target <= access.target;
      pend_err    <= access_err;
    end
  end

  // Error reads return zero
  always_comb begin
    rd_sel = '0;
    if (!pend_err) begin
      rd_sel = (pend_target == TGT_TAP) ? tap_rdata : reg_rdata;
    end
  end

  // Valid raised two edges after acceptance, dropped on handshake
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      rvalid <= 1'b0;
      bvalid <= 1'b0;
    end else begin
      if (pend_q && !pend_write) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
      if (pend_q && pend_write) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // Payload is loaded once and then held under back-pressure
  always_ff @(posedge aclk) begin
    if (pend_q && !pend_write) begin
      rdata <= rd_sel;
      rresp <= pend_err ? RESP_SLVERR : RESP_OKAY;
    end
    if (pend_q && pend_write) begin
      bresp <= pend_err ? RESP_SLVERR : RESP_OKAY;
    end
  end

  assign resp_busy = access_valid || pend_q || rvalid || bvalid;

endmodule

/* verilog/axil_cfg_slave.sv */
// Top of the FIR config slave: AXI4-Lite bus on one side, tap memory and start/done on the other
`timescale 1ns/1ns

module axil_cfg_slave
  import axil_pkg::*;
  import fir_cfg_pkg::*;
(
  input  logic              aclk,
  input  logic              aresetn,

  ////////////////////////////////////////////////////////////////////////////
  // AXI4-Lite
  ////////////////////////////////////////////////////////////////////////////

  input  logic [ADDR_W-1:0] araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [DATA_W-1:0] rdata,
  output resp_t             rresp,
  output logic              rvalid,
  input  logic              rready,
  input  logic [ADDR_W-1:0] awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [DATA_W-1:0] wdata,
  input  logic [STRB_W-1:0] wstrb,
  input  logic              wvalid,
  output logic              wready,
  output resp_t             bresp,
  output logic              bvalid,
  input  logic              bready,

  ////////////////////////////////////////////////////////////////////////////
  // Engine
  ////////////////////////////////////////////////////////////////////////////

  output logic              ap_start,
  input  logic              ap_done,
  output logic [DATA_W-1:0] data_length,
  input  logic [TAP_AW-1:0] tap_raddr,
  output logic [DATA_W-1:0] eng_tap_rdata
);

  logic              access_valid;
  axil_access_t      access;
  logic              access_err;
  logic              resp_busy;
  logic              ap_idle;
  logic [DATA_W-1:0] reg_rdata;
  logic [DATA_W-1:0] tap_rdata;

  // Address and data capture
  axil_req_capture i_capture (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .araddr       (araddr),
    .arvalid      (arvalid),
    .arready      (arready),
    .awaddr       (awaddr),
    .awvalid      (awvalid),
    .awready      (awready),
    .wdata        (wdata),
    .wstrb        (wstrb),
    .wvalid       (wvalid),
    .wready       (wready),
    .resp_busy    (resp_busy),
    .ap_idle      (ap_idle),
    .access_valid (access_valid),
    .access       (access),
    .access_err   (access_err)
  );

  // Control and length registers
  cfg_reg_block i_regs (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .access_valid (access_valid),
    .access       (access),
    .access_err   (access_err),
    .ap_done      (ap_done),
    .ap_start     (ap_start),
    .ap_idle      (ap_idle),
    .data_length  (data_length),
    .reg_rdata    (reg_rdata)
  );

  // Tap coefficients
  tap_ram i_taps (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .access_valid  (access_valid),
    .access        (access),
    .access_err    (access_err),
    .tap_rdata     (tap_rdata),
    .tap_raddr     (tap_raddr),
    .eng_tap_rdata (eng_tap_rdata)
  );

  // R and B channels
  axil_resp_gen i_resp (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .access_valid (access_valid),
    .access       (access),
    .access_err   (access_err),
    .reg_rdata    (reg_rdata),
    .tap_rdata    (tap_rdata),
    .rdata        (rdata),
    .rresp        (rresp),
    .rvalid       (rvalid),
    .rready       (rready),
    .bresp        (bresp),
    .bvalid       (bvalid),
    .bready       (bready),
    .resp_busy    (resp_busy)
  );

endmodule

/* verif/axil_cfg_asserts.sv */
// AXI4-Lite protocol checks for the config slave, bound into every axil_cfg_slave instance
`timescale 1ns/1ns

module axil_cfg_asserts
  import axil_pkg::*;
(
  input logic              aclk,
  input logic              aresetn,
  input logic              arvalid,
  input logic              arready,
  input logic              awvalid,
  input logic              awready,
  input logic              wready,
  input logic [DATA_W-1:0] rdata,
  input resp_t             rresp,
  input logic              rvalid,
  input logic              rready,
  input resp_t             bresp,
  input logic              bvalid,
  input logic              bready
);

  // Failure count, read back by the testbench
  int unsigned assert_fails = 0;

  // R holds with its payload until taken
  r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
      assert_fails++;
      $error("R channel dropped or changed before rready");
    end

  // Same for B
  b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      assert_fails++;
      $error("B channel dropped or changed before bready");
    end

  // No address is taken while a response is still out
  no_accept_busy: assert property (@(posedge aclk) disable iff (!aresetn)
    (arready || awready || wready) |-> !rvalid && !bvalid)
    else begin
      assert_fails++;
      $error("Address ready raised while a response was pending");
    end

  // Valid is set by the edge two after acceptance, so it samples high on the third
  r_latency: assert property (@(posedge aclk) disable iff (!aresetn)
    arvalid && arready |-> ##3 $rose(rvalid))
    else begin
      assert_fails++;
      $error("rvalid did not rise two cycles after read acceptance");
    end

  b_latency: assert property (@(posedge aclk) disable iff (!aresetn)
    awvalid && awready |-> ##3 $rose(bvalid))
    else begin
      assert_fails++;
      $error("bvalid did not rise two cycles after write acceptance");
    end

endmodule

bind axil_cfg_slave axil_cfg_asserts i_asserts (
  .aclk    (aclk),
  .aresetn (aresetn),
  .arvalid (arvalid),
  .arready (arready),
  .awvalid (awvalid),
  .awready (awready),
  .wready  (wready),
  .rdata   (rdata),
  .rresp   (rresp),
  .rvalid  (rvalid),
  .rready  (rready),
  .bresp   (bresp),
  .bvalid  (bvalid),
  .bready  (bready)
);

/* verif/tb_axil_cfg_slave.sv */
// Testbench for the FIR config slave: LCG driven bus traffic checked against a register model
`timescale 1ns/1ns

module tb_axil_cfg_slave
  import axil_pkg::*;
  import fir_cfg_pkg::*;
();

  logic              aclk;
  logic              aresetn;
  logic [ADDR_W-1:0] araddr;
  logic [ADDR_W-1:0] awaddr;
  logic              arvalid, arready, rvalid, rready;
  logic              awvalid, awready, wvalid, wready, bvalid, bready;
  logic [DATA_W-1:0] rdata, wdata, data_length, eng_tap_rdata;
  logic [STRB_W-1:0] wstrb;
  resp_t             rresp, bresp;
  logic              ap_start, ap_done;
  logic [TAP_AW-1:0] tap_raddr;

  // Reference model state
  logic [DATA_W-1:0] tap_m [TAP_NUM];
  logic [DATA_W-1:0] len_m;
  logic              done_m, idle_m;
  int                starts_exp = 0;
  int                starts_seen = 0;

  // Generator state, bookkeeping
  logic [31:0]       rng = 32'h421f_db05;
  logic [31:0]       eng_rng;
  int                eng_wait;
  int                cycles = 0;
  int                checks = 0;
  int                errors = 0;
  int                test_errors = 0;
  int                tests = 0;
  string             test_name;
  logic [ADDR_W-1:0] bad_addr [6] = '{12'h001, 12'h042, 12'h013, 12'h004, 12'h06c, 12'hffc};

  axil_cfg_slave i_dut (.*);

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  // Watchdog, roughly five times the expected run length
  always @(posedge aclk) begin
    cycles++;
    if (cycles >= 20000) begin
      $display("Simulation hung: no end of test after %0d cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Halves swapped so the small ranges use the better upper bits
  function automatic logic [31:0] draw();
    rng = lcg_step(rng);
    return {rng[15:0], rng[31:16]};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] strb);
    logic [31:0] res;
    for (int i = 0; i < 4; i++) begin
      res[8*i +: 8] = strb[i] ? new_w[8*i +: 8] : old_w[8*i +: 8];
    end
    return res;
  endfunction

  // Register map target: 0 control, 1 length, 2 tap, 3 unmapped
  function automatic int map_target(input logic [ADDR_W-1:0] addr);
    if (addr[1:0] != 2'b00) return 3;
    if (addr == ADDR_W'(CTRL_OFFSET)) return 0;
    if (addr == ADDR_W'(LEN_OFFSET)) return 1;
    if (addr >= ADDR_W'(TAP_BASE) && addr <= ADDR_W'(TAP_BASE + 4 * (TAP_NUM - 1))) return 2;
    return 3;
  endfunction

  // Mostly mapped, one in eight anywhere in the space
  function automatic logic [ADDR_W-1:0] pick_addr(input logic [31:0] r);
    case (r % 8)
      0:       return ADDR_W'(CTRL_OFFSET);
      1:       return ADDR_W'(LEN_OFFSET);
      7:       return r[27:16];
      default: return ADDR_W'(TAP_BASE + 4 * ((r >> 8) % TAP_NUM));
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      test_errors++;
      $display("[ERROR] %s, %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic next_cycle();
    @(posedge aclk);
    #2;
  endtask

  task automatic finish_test();
    tests++;
    if (test_errors == 0) begin
      $display("%s: ok", test_name);
    end else begin
      $display("%s: %0d errors", test_name, test_errors);
    end
    test_errors = 0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus transactions
  ////////////////////////////////////////////////////////////////////////////

  task automatic bus_read(input logic [ADDR_W-1:0] addr);
    int          tgt;
    int          lat;
    logic [31:0] exp_data;
    tgt     = map_target(addr);
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge aclk);
    while (!arready) @(negedge aclk);
    next_cycle();
    arvalid = 1'b0;
    // Model now holds what the DUT samples on the next edge
    case (tgt)
      0: begin
        exp_data = {29'd0, idle_m, done_m, 1'b0};
        done_m   = 1'b0;
      end
      1:       exp_data = len_m;
      2:       exp_data = tap_m[(addr - ADDR_W'(TAP_BASE)) >> 2];
      default: exp_data = '0;
    endcase
    lat = 0;
    while (!rvalid) begin
      next_cycle();
      lat++;
    end
    check_value("read latency", 2, lat);
    check_value("rresp", (tgt == 3) ? RESP_SLVERR : RESP_OKAY, 32'(rresp));
    check_value("rdata", exp_data, rdata);
    repeat (draw() % 4) begin
      next_cycle();
      check_value("rvalid under stall", 1, 32'(rvalid));
      check_value("rdata under stall", exp_data, rdata);
    end
    rready = 1'b1;
    next_cycle();
    rready = 1'b0;
    check_value("rvalid after handshake", 0, 32'(rvalid));
  endtask

  task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    int                tgt;
    int                lat;
    logic              exp_err;
    logic [TAP_AW-1:0] idx;
    tgt     = map_target(addr);
    idx     = TAP_AW'((addr - ADDR_W'(TAP_BASE)) >> 2);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge aclk);
    while (!awready) @(negedge aclk);
    check_value("wready with awready", 1, 32'(wready));
    // Tap writes are refused while the engine runs
    exp_err = (tgt == 3) || (tgt == 2 && !idle_m);
    next_cycle();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (!exp_err) begin
      case (tgt)
        0: begin
          if (idle_m && strb[0] && data[0]) begin
            starts_exp++;
          end
        end
        1:       len_m = merge_bytes(len_m, data, strb);
        2:       tap_m[idx] = merge_bytes(tap_m[idx], data, strb);
        default: ;
      endcase
    end
    lat = 0;
    while (!bvalid) begin
      next_cycle();
      lat++;
    end
    check_value("write latency", 2, lat);
    check_value("bresp", exp_err ? RESP_SLVERR : RESP_OKAY, 32'(bresp));
    repeat (draw() % 4) begin
      next_cycle();
      check_value("bvalid under stall", 1, 32'(bvalid));
      check_value("bresp under stall", exp_err ? RESP_SLVERR : RESP_OKAY, 32'(bresp));
    end
    bready = 1'b1;
    next_cycle();
    bready = 1'b0;
    check_value("bvalid after handshake", 0, 32'(bvalid));
    check_value("ap_start pulses", starts_exp, starts_seen);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Engine model
  ////////////////////////////////////////////////////////////////////////////

  // Model updates at +1, ap_done driven at +2
  initial begin
    ap_done  = 1'b0;
    eng_wait = 0;
    forever begin
      @(posedge aclk);
      #1;
      if (ap_done) begin
        done_m = 1'b1;
        idle_m = 1'b1;
      end
      if (ap_start) begin
        starts_seen++;
        idle_m   = 1'b0;
        eng_rng  = lcg_step(eng_rng);
        eng_wait = 2 + int'(eng_rng[31:16] % 19);
      end
      #1;
      ap_done = 1'b0;
      if (eng_wait > 0) begin
        eng_wait--;
        ap_done = (eng_wait == 0);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    int          tidx;
    aresetn   = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    tap_raddr = '0;
    len_m     = '0;
    done_m    = 1'b0;
    idle_m    = 1'b1;
    for (int i = 0; i < TAP_NUM; i++) begin
      tap_m[i] = '0;
    end
    eng_rng = draw();

    // 1. Reset state
    test_name = "reset";
    repeat (5) begin
      next_cycle();
      check_value("ready/valid in reset", 0,
                  32'({arready, awready, wready, rvalid, bvalid, ap_start}));
    end
    aresetn = 1'b1;
    bus_read(ADDR_W'(CTRL_OFFSET));
    finish_test();

    // 2. Tap load with random strobes, then bus and engine readback
    test_name = "tap_load";
    repeat (200) begin
      tidx = int'(draw() % TAP_NUM);
      bus_write(ADDR_W'(TAP_BASE + 4 * tidx), draw(), 4'(draw()));
    end
    for (int i = 0; i < TAP_NUM; i++) begin
      bus_read(ADDR_W'(TAP_BASE + 4 * i));
    end
    for (int i = 0; i < TAP_NUM; i++) begin
      tap_raddr = TAP_AW'(i);
      next_cycle();
      check_value("engine tap read", tap_m[i], eng_tap_rdata);
    end
    finish_test();

    // 3. Start, busy tap write, done and its clear on read
    test_name = "start_done";
    repeat (8) begin
      tidx = int'(draw() % TAP_NUM);
      bus_write(ADDR_W'(CTRL_OFFSET), 32'h1, 4'hf);
      bus_read(ADDR_W'(CTRL_OFFSET));
      bus_write(ADDR_W'(TAP_BASE + 4 * tidx), draw(), 4'hf);
      bus_read(ADDR_W'(TAP_BASE + 4 * tidx));
      while (!idle_m) next_cycle();
      bus_read(ADDR_W'(CTRL_OFFSET));
      bus_read(ADDR_W'(CTRL_OFFSET));
    end
    finish_test();

    // 4. Unaligned and unmapped addresses
    test_name = "error_resp";
    foreach (bad_addr[i]) begin
      bus_write(bad_addr[i], draw(), 4'hf);
      bus_read(bad_addr[i]);
    end
    bus_read(ADDR_W'(LEN_OFFSET));
    finish_test();

    // 5. Mixed random traffic under ready stalls
    test_name = "backpressure";
    repeat (300) begin
      r = draw();
      if (r[20]) begin
        bus_write(pick_addr(draw()), draw(), 4'(draw()));
      end else begin
        bus_read(pick_addr(draw()));
      end
    end
    bus_read(ADDR_W'(LEN_OFFSET));
    check_value("data_length port", len_m, data_length);
    finish_test();

    $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
             tests, checks, errors, i_dut.i_asserts.assert_fails);
    if (errors == 0 && i_dut.i_asserts.assert_fails == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* src.f */
verilog/fir_cfg_pkg.sv
verilog/axil_pkg.sv
verilog/axil_req_capture.sv
verilog/cfg_reg_block.sv
verilog/tap_ram.sv
verilog/axil_resp_gen.sv
verilog/axil_cfg_slave.sv
verif/axil_cfg_asserts.sv
verif/tb_axil_cfg_slave.sv
